//--- rtl/pma_pkg.sv
//##########################################################################
// PMA checker types: region attributes, requests, responses, reset values
//##########################################################################
`default_nettype none

package pma_pkg;

  // Region count, one region per value of address bits 31:28
  localparam int N_REGIONS = 16;

  // Ordered so that a numeric compare means "wider than"
  typedef enum logic [1:0] {
    ACC_BYTE     = 2'd0,
    ACC_HALF     = 2'd1,
    ACC_WORD     = 2'd2,
    ACC_RESERVED = 2'd3
  } acc_width_t;

  // Reservation support codes
  typedef enum logic [1:0] {
    RSRV_NONE         = 2'd0,
    RSRV_NON_EVENTUAL = 2'd1,
    RSRV_EVENTUAL     = 2'd2,
    RSRV_RESERVED     = 2'd3
  } rsrv_t;

  // One 16-bit region configuration, MSB first
  typedef struct packed {
    logic [1:0] reserved;
    logic       w;
    logic       r;
    logic       x;
    acc_width_t acc_width;
    logic       idempotent;
    logic       cacheable;
    logic       coherent;
    rsrv_t      rsrv;
    // AMO class, stored only
    logic [2:0] amo;
    logic       is_memory;
  } pma_cfg_t;

  // Low half applies when address bit 27 is clear
  typedef struct packed {
    pma_cfg_t cfg_1;
    pma_cfg_t cfg_0;
  } pma_pair_t;

  // CSR view is the raw word, lookup view is the two halves
  typedef union packed {
    logic [31:0] raw;
    pma_pair_t   half;
  } pma_reg_u;

  // Reset configurations
  localparam pma_cfg_t RAM_CFG = '{
    reserved: 2'b00, w: 1'b1, r: 1'b1, x: 1'b1, acc_width: ACC_WORD,
    idempotent: 1'b1, cacheable: 1'b1, coherent: 1'b1,
    rsrv: RSRV_EVENTUAL, amo: 3'd0, is_memory: 1'b1
  };
  localparam pma_cfg_t IO_CFG = '{
    reserved: 2'b00, w: 1'b1, r: 1'b1, x: 1'b1, acc_width: ACC_WORD,
    idempotent: 1'b0, cacheable: 1'b0, coherent: 1'b1,
    rsrv: RSRV_EVENTUAL, amo: 3'd0, is_memory: 1'b0
  };

  typedef enum logic [1:0] {
    KIND_LOAD  = 2'd0,
    KIND_STORE = 2'd1,
    KIND_FETCH = 2'd2
  } access_kind_t;

  typedef enum logic [1:0] {
    FAULT_NONE  = 2'd0,
    FAULT_LOAD  = 2'd1,
    FAULT_STORE = 2'd2,
    FAULT_FETCH = 2'd3
  } fault_t;

  // Memory access request, 40 bits
  typedef struct packed {
    logic [31:0]  addr;
    access_kind_t kind;
    acc_width_t   width;
    logic [3:0]   tag;
  } pma_req_t;

  // Request with its selected configuration, 56 bits
  typedef struct packed {
    pma_req_t req;
    pma_cfg_t cfg;
  } pma_lookup_t;

  typedef struct packed {
    logic [3:0] tag;
    fault_t     fault;
  } pma_resp_t;

endpackage

`default_nettype wire

//--- rtl/pma_attr_regs.sv
//##########################################################################
// PMA region attribute file with CSR access, WARL legalization, lookup port
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_attr_regs
  import pma_pkg::*;
(
  input  wire logic        CLK,
  input  wire logic        nRST,
  // CSR port
  input  wire logic [11:0] csr_addr_i,
  input  wire logic        csr_wen_i,
  input  wire pma_reg_u    csr_wdata_i,
  output pma_reg_u         csr_rdata_o,
  output logic             csr_ack_o,
  // Lookup read port
  input  wire logic [3:0]  region_i,
  output pma_reg_u         region_attr_o
);

  pma_reg_u   regs [N_REGIONS];
  pma_reg_u   wr_word;
  pma_reg_u   legal_word;
  logic       rw_hit;
  logic       ro_hit;
  logic       wr_en;

  // WARL rule for one half
  function automatic pma_cfg_t legalize(input pma_cfg_t cfg);
    pma_cfg_t fixed;
    fixed = cfg;
    // Reserved reservation code reads back as none
    if (cfg.rsrv == RSRV_RESERVED) begin
      fixed.rsrv = RSRV_NONE;
    end
    // Reserved width reads back as word
    if (cfg.acc_width == ACC_RESERVED) begin
      fixed.acc_width = ACC_WORD;
    end
    return fixed;
  endfunction

  // Window decode on the upper address byte
  assign rw_hit    = (csr_addr_i[11:4] == 8'hBC);
  assign ro_hit    = (csr_addr_i[11:4] == 8'hCC);
  assign csr_ack_o = rw_hit | ro_hit;

  // Only the read-write window accepts writes
  assign wr_en = csr_wen_i & rw_hit;

  // Write data comes in as a raw word, then each half is fixed up
  always_comb begin
    wr_word.raw           = csr_wdata_i.raw;
    legal_word.half.cfg_0 = legalize(wr_word.half.cfg_0);
    legal_word.half.cfg_1 = legalize(wr_word.half.cfg_1);
  end

  // Both windows read the same register
  assign csr_rdata_o = regs[csr_addr_i[3:0]];

  // Lookup side, combinational
  assign region_attr_o = regs[region_i];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      // Lower half of the map is RAM, upper half is IO
      for (int i = 0; i < N_REGIONS; i++) begin
        if (i < N_REGIONS / 2) begin
          regs[i].half.cfg_0 <= RAM_CFG;
          regs[i].half.cfg_1 <= RAM_CFG;
        end else begin
          regs[i].half.cfg_0 <= IO_CFG;
          regs[i].half.cfg_1 <= IO_CFG;
        end
      end
    end else if (wr_en) begin
      regs[csr_addr_i[3:0]] <= legal_word;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pma_req_queue.sv
//##########################################################################
// Credited request FIFO, returns one upstream credit per popped entry
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_req_queue
  import pma_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4
) (
  input  wire logic     CLK,
  input  wire logic     nRST,
  input  wire logic     req_valid_i,
  input  wire pma_req_t req_i,
  input  wire logic     pop_i,
  output logic          q_valid_o,
  output pma_req_t      q_req_o,
  output logic          req_credit_o
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  pma_req_t           mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   count;
  logic               do_pop;

  // Pointer wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign q_valid_o = (count != '0);
  assign q_req_o   = mem[rd_ptr];
  // Ignore a pop on an empty queue
  assign do_pop    = pop_i & q_valid_o;

  // Storage, no reset; upstream credits guarantee a free slot
  always_ff @(posedge CLK) begin
    if (req_valid_i) begin
      mem[wr_ptr] <= req_i;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      req_credit_o <= 1'b0;
    end else begin
      if (req_valid_i) begin
        wr_ptr <= ptr_next(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_next(rd_ptr);
      end
      // Simultaneous push and pop leave the count alone
      if (req_valid_i && !do_pop) begin
        count <= count + 1'b1;
      end else if (!req_valid_i && do_pop) begin
        count <= count - 1'b1;
      end
      // Slot freed, hand one credit back
      req_credit_o <= do_pop;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pma_lookup_stage.sv
//##########################################################################
// Region lookup stage, selects the region half and registers its config
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_lookup_stage
  import pma_pkg::*;
(
  input  wire logic     CLK,
  input  wire logic     nRST,
  // From the queue head
  input  wire logic     q_valid_i,
  input  wire pma_req_t q_req_i,
  output logic          pop_o,
  // Attribute table port
  output logic [3:0]    region_o,
  input  wire pma_reg_u region_attr_i,
  // Towards the check stage
  input  wire logic     stall_i,
  output logic          lk_valid_o,
  output pma_lookup_t   lk_data_o
);

  pma_cfg_t sel_cfg;
  logic     advance;

  // Region from the top nibble of the head address
  assign region_o = q_req_i.addr[31:28];

  // Bit 27 picks the half
  assign sel_cfg = q_req_i.addr[27] ? region_attr_i.half.cfg_1
                                    : region_attr_i.half.cfg_0;

  // Load when empty or when the check stage takes the current item
  assign advance = q_valid_i & (!lk_valid_o | !stall_i);
  assign pop_o   = advance;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      lk_valid_o <= 1'b0;
    end else if (advance) begin
      lk_valid_o <= 1'b1;
    end else if (!stall_i) begin
      // Item handed on, nothing new behind it
      lk_valid_o <= 1'b0;
    end
  end

  // Payload, no reset
  always_ff @(posedge CLK) begin
    if (advance) begin
      lk_data_o.req <= q_req_i;
      lk_data_o.cfg <= sel_cfg;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pma_check_stage.sv
//##########################################################################
// Fault check stage with output register and downstream credit counter
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_check_stage
  import pma_pkg::*;
#(
  parameter int OUT_CREDITS = 2
) (
  input  wire logic        CLK,
  input  wire logic        nRST,
  input  wire logic        lk_valid_i,
  input  wire pma_lookup_t lk_data_i,
  output logic             stall_o,
  input  wire logic        resp_credit_i,
  output logic             resp_valid_o,
  output pma_resp_t        resp_o
);

  localparam int CRD_W = $clog2(OUT_CREDITS + 1);

  logic [CRD_W-1:0] credit_cnt;
  logic             pend_valid;
  pma_resp_t        pend_resp;
  fault_t           fault;
  logic             too_wide;
  logic             take;
  logic             send;

  // Width check is shared by all three kinds
  assign too_wide = (lk_data_i.req.width > lk_data_i.cfg.acc_width);

  always_comb begin
    fault = FAULT_NONE;
    case (lk_data_i.req.kind)
      KIND_LOAD: begin
        if (!lk_data_i.cfg.r || too_wide) fault = FAULT_LOAD;
      end
      KIND_STORE: begin
        if (!lk_data_i.cfg.w || too_wide) fault = FAULT_STORE;
      end
      KIND_FETCH: begin
        if (!lk_data_i.cfg.x || too_wide) fault = FAULT_FETCH;
      end
      default: fault = FAULT_NONE;
    endcase
  end

  // Send needs a pending result and a credit
  assign send         = pend_valid & (credit_cnt != '0);
  assign resp_valid_o = send;
  assign resp_o       = pend_resp;

  // Output slot is free if empty or leaving this cycle
  assign stall_o = pend_valid & !send;
  assign take    = lk_valid_i & !stall_o;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pend_valid <= 1'b0;
      credit_cnt <= CRD_W'(OUT_CREDITS);
    end else begin
      if (take) begin
        pend_valid <= 1'b1;
      end else if (send) begin
        pend_valid <= 1'b0;
      end
      // Return and spend in one cycle cancel out
      if (send && !resp_credit_i) begin
        credit_cnt <= credit_cnt - 1'b1;
      end else if (!send && resp_credit_i) begin
        credit_cnt <= credit_cnt + 1'b1;
      end
    end
  end

  // Result payload
  always_ff @(posedge CLK) begin
    if (take) begin
      pend_resp.tag   <= lk_data_i.req.tag;
      pend_resp.fault <= fault;
    end
  end

endmodule

`default_nettype wire

//--- rtl/pma_checker_top.sv
//##########################################################################
// PMA checker top: attribute table, request queue, lookup and check stages
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_checker_top
  import pma_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input  wire logic        CLK,
  input  wire logic        nRST,
  // Requests, credited upstream
  input  wire logic        req_valid_i,
  input  wire pma_req_t    req_i,
  output logic             req_credit_o,
  // Responses, credited downstream
  output logic             resp_valid_o,
  output pma_resp_t        resp_o,
  input  wire logic        resp_credit_i,
  // CSR port
  input  wire logic [11:0] csr_addr_i,
  input  wire logic        csr_wen_i,
  input  wire pma_reg_u    csr_wdata_i,
  output pma_reg_u         csr_rdata_o,
  output logic             csr_ack_o
);

  logic        q_valid;
  pma_req_t    q_req;
  logic        q_pop;
  logic [3:0]  region_idx;
  pma_reg_u    region_attr;
  logic        lk_valid;
  pma_lookup_t lk_data;
  logic        chk_stall;

  pma_attr_regs u_attr_regs (
    .CLK(CLK), .nRST(nRST),
    .csr_addr_i(csr_addr_i), .csr_wen_i(csr_wen_i), .csr_wdata_i(csr_wdata_i),
    .csr_rdata_o(csr_rdata_o), .csr_ack_o(csr_ack_o),
    .region_i(region_idx), .region_attr_o(region_attr)
  );

  pma_req_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_req_queue (
    .CLK(CLK), .nRST(nRST),
    .req_valid_i(req_valid_i), .req_i(req_i), .pop_i(q_pop),
    .q_valid_o(q_valid), .q_req_o(q_req), .req_credit_o(req_credit_o)
  );

  pma_lookup_stage u_lookup (
    .CLK(CLK), .nRST(nRST),
    .q_valid_i(q_valid), .q_req_i(q_req), .pop_o(q_pop),
    .region_o(region_idx), .region_attr_i(region_attr),
    .stall_i(chk_stall), .lk_valid_o(lk_valid), .lk_data_o(lk_data)
  );

  pma_check_stage #(.OUT_CREDITS(OUT_CREDITS)) u_check (
    .CLK(CLK), .nRST(nRST),
    .lk_valid_i(lk_valid), .lk_data_i(lk_data), .stall_o(chk_stall),
    .resp_credit_i(resp_credit_i), .resp_valid_o(resp_valid_o), .resp_o(resp_o)
  );

endmodule

`default_nettype wire

//--- sim/pma_checker_properties.sv
//##########################################################################
// PMA checker assertions on credits, queue occupancy and output validity
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_checker_properties
  import pma_pkg::*;
#(
  parameter int QUEUE_DEPTH = 4,
  parameter int OUT_CREDITS = 2
) (
  input wire logic                               CLK,
  input wire logic                               nRST,
  input wire logic [$clog2(QUEUE_DEPTH+1)-1:0]   q_count,
  input wire logic [$clog2(OUT_CREDITS+1)-1:0]   credit_cnt,
  input wire logic                               resp_valid_o,
  input wire pma_resp_t                          resp_o,
  input wire logic                               resp_credit_i,
  input wire logic                               req_credit_o,
  input wire logic                               csr_ack_o
);

  int unsigned credits_used;

  // Downstream credits in use, counted from the port handshakes alone
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      credits_used <= 0;
    end else if (resp_valid_o && !resp_credit_i) begin
      credits_used <= credits_used + 1;
    end else if (!resp_valid_o && resp_credit_i) begin
      credits_used <= credits_used - 1;
    end
  end

  // Upstream credits bound the occupancy
  queue_bound: assert property (@(posedge CLK) disable iff (!nRST)
    int'(q_count) <= QUEUE_DEPTH)
    else $error("request queue holds more entries than its depth");

  // Downstream returns never push the counter past its start value
  credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
    int'(credit_cnt) <= OUT_CREDITS)
    else $error("downstream credit counter above its reset value");

  // A response always spends a credit that exists
  send_needs_credit: assert property (@(posedge CLK) disable iff (!nRST)
    resp_valid_o |-> (credits_used < OUT_CREDITS))
    else $error("response sent with no downstream credit");

  // Control outputs known once out of reset
  ctrl_known: assert property (@(posedge CLK) disable iff (!nRST)
    !$isunknown({resp_valid_o, req_credit_o, csr_ack_o}))
    else $error("unknown value on a control output");

  // Payload only matters while valid
  resp_known: assert property (@(posedge CLK) disable iff (!nRST)
    resp_valid_o |-> !$isunknown(resp_o))
    else $error("unknown response payload while valid");

endmodule

bind pma_checker_top pma_checker_properties #(
  .QUEUE_DEPTH(QUEUE_DEPTH),
  .OUT_CREDITS(OUT_CREDITS)
) u_properties (
  .CLK(CLK), .nRST(nRST),
  .q_count(u_req_queue.count), .credit_cnt(u_check.credit_cnt),
  .resp_valid_o(resp_valid_o), .resp_o(resp_o), .resp_credit_i(resp_credit_i),
  .req_credit_o(req_credit_o), .csr_ack_o(csr_ack_o)
);

`default_nettype wire

//--- sim/pma_checker_tb.sv
//##########################################################################
// PMA checker testbench, random CSR and request traffic against a model
//##########################################################################
`timescale 1ns/1ns
`default_nettype none

module pma_checker_tb
  import pma_pkg::*;
();

  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS = 2;
  localparam int TIMEOUT_CYC = 2000;

  logic        CLK;
  logic        nRST;
  logic        req_valid;
  pma_req_t    req;
  logic        req_credit;
  logic        resp_valid;
  pma_resp_t   resp;
  logic        resp_credit;
  logic [11:0] csr_addr;
  logic        csr_wen;
  pma_reg_u    csr_wdata;
  pma_reg_u    csr_rdata;
  logic        csr_ack;

  // Reference state
  pma_reg_u    model_regs [N_REGIONS];
  pma_resp_t   exp_q [$];
  int          resp_seen     = 0;
  int          up_sent       = 0;
  int          up_returned   = 0;
  int          credits_given = 0;
  bit          slow_credits  = 1'b0;
  bit          timed_out     = 1'b0;
  int          err_stream    = 0;
  int          err_csr       = 0;
  int          err_misc      = 0;

  pma_checker_top #(
    .QUEUE_DEPTH(QUEUE_DEPTH),
    .OUT_CREDITS(OUT_CREDITS)
  ) u_dut (
    .CLK(CLK), .nRST(nRST),
    .req_valid_i(req_valid), .req_i(req), .req_credit_o(req_credit),
    .resp_valid_o(resp_valid), .resp_o(resp), .resp_credit_i(resp_credit),
    .csr_addr_i(csr_addr), .csr_wen_i(csr_wen), .csr_wdata_i(csr_wdata),
    .csr_rdata_o(csr_rdata), .csr_ack_o(csr_ack)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Reserved reservation code becomes none and reserved width becomes word
  function automatic pma_cfg_t warl_cfg(input pma_cfg_t c);
    pma_cfg_t f;
    f = c;
    if (c.rsrv == RSRV_RESERVED) f.rsrv = RSRV_NONE;
    if (c.acc_width == ACC_RESERVED) f.acc_width = ACC_WORD;
    return f;
  endfunction

  // Response expected for a request under the current model table
  function automatic pma_resp_t expected_resp(input pma_req_t r);
    pma_reg_u  word;
    pma_cfg_t  cfg;
    pma_resp_t e;
    bit        allowed;
    word = model_regs[r.addr[31:28]];
    cfg  = r.addr[27] ? word.half.cfg_1 : word.half.cfg_0;
    case (r.kind)
      KIND_LOAD:  allowed = cfg.r;
      KIND_STORE: allowed = cfg.w;
      default:    allowed = cfg.x;
    endcase
    // Wider than the region allows
    if (r.width > cfg.acc_width) allowed = 1'b0;
    e.tag = r.tag;
    if (allowed) e.fault = FAULT_NONE;
    else if (r.kind == KIND_LOAD) e.fault = FAULT_LOAD;
    else if (r.kind == KIND_STORE) e.fault = FAULT_STORE;
    else e.fault = FAULT_FETCH;
    return e;
  endfunction

  function automatic pma_req_t random_req(input logic [3:0] tag);
    pma_req_t r;
    r.addr  = $urandom;
    r.kind  = access_kind_t'(2'($urandom_range(2)));
    // Request width may be the reserved code, which always faults
    r.width = acc_width_t'(2'($urandom_range(3)));
    r.tag   = tag;
    return r;
  endfunction

  task automatic check_resp(input pma_resp_t got, input pma_resp_t exp);
    if (got !== exp) begin
      err_stream++;
      $display("ERROR %0t resp_o: got tag %0h fault %0d, expected tag %0h fault %0d",
               $time, got.tag, got.fault, exp.tag, exp.fault);
    end
  endtask

  task automatic check_csr(input pma_reg_u got, input pma_reg_u exp, input string name);
    if (got !== exp) begin
      err_csr++;
      $display("ERROR %0t %s: got %h, expected %h", $time, name, got.raw, exp.raw);
    end
  endtask

  task automatic check_ack(input bit got, input bit exp, input string name);
    if (got !== exp) begin
      err_csr++;
      $display("ERROR %0t %s: got %0b, expected %0b", $time, name, got, exp);
    end
  endtask

  task automatic end_run();
    $display("Error counts: responses %0d, csr %0d, other %0d",
             err_stream, err_csr, err_misc);
    if (err_stream == 0 && err_csr == 0 && err_misc == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  // Drive the address on one edge and check the combinational read data mid-cycle
  task automatic csr_read(input logic [11:0] addr, input bit exp_ack, input pma_reg_u exp);
    @(posedge CLK);
    csr_addr <= addr;
    csr_wen  <= 1'b0;
    @(negedge CLK);
    check_ack(csr_ack, exp_ack, "csr_ack_o");
    if (exp_ack) check_csr(csr_rdata, exp, "csr_rdata_o");
  endtask

  task automatic csr_write(input logic [11:0] addr, input pma_reg_u data);
    @(posedge CLK);
    csr_addr  <= addr;
    csr_wen   <= 1'b1;
    csr_wdata <= data;
    @(posedge CLK);
    csr_wen <= 1'b0;
    // Read-only window leaves the table alone
    if (addr[11:4] == 8'hBC) begin
      model_regs[addr[3:0]].half.cfg_0 = warl_cfg(data.half.cfg_0);
      model_regs[addr[3:0]].half.cfg_1 = warl_cfg(data.half.cfg_1);
    end
  endtask

  // Waits for an upstream credit, then drives one request for a cycle
  task automatic send_req(input pma_req_t r);
    int waited;
    waited = 0;
    if (timed_out) return;
    @(posedge CLK);
    while (up_sent - up_returned >= QUEUE_DEPTH && waited < TIMEOUT_CYC) begin
      req_valid <= 1'b0;
      @(posedge CLK);
      waited++;
    end
    if (waited >= TIMEOUT_CYC) begin
      err_misc++;
      timed_out = 1'b1;
      $display("Timeout: no upstream credit came back for tag %0h", r.tag);
    end else begin
      req_valid <= 1'b1;
      req       <= r;
      up_sent++;
      exp_q.push_back(expected_resp(r));
    end
  endtask

  // Idle once every expected response is back
  // Upstream credits return before the response of the same entry
  task automatic drain(input string what);
    int waited;
    waited = 0;
    if (timed_out) return;
    @(posedge CLK);
    req_valid <= 1'b0;
    while (resp_seen != exp_q.size() && waited < TIMEOUT_CYC) begin
      @(posedge CLK);
      waited++;
    end
    if (waited >= TIMEOUT_CYC) begin
      err_misc++;
      timed_out = 1'b1;
      $display("Timeout: %s did not drain, %0d responses missing",
               what, exp_q.size() - resp_seen);
    end
  endtask

  // Downstream credit return is held back for random stretches in slow mode
  initial begin
    int hold_left;
    hold_left   = 0;
    resp_credit = 1'b0;
    forever begin
      @(posedge CLK);
      resp_credit <= 1'b0;
      if (hold_left > 0) begin
        hold_left--;
      end else if (resp_seen > credits_given) begin
        if (slow_credits && $urandom_range(3) == 0) begin
          hold_left = $urandom_range(20, 4);
        end else begin
          resp_credit <= 1'b1;
          credits_given++;
        end
      end
    end
  end

  // Output monitor samples mid-cycle
  always @(negedge CLK) begin
    if (nRST) begin
      if (req_credit) begin
        up_returned++;
        if (up_returned > up_sent) begin
          err_stream++;
          $display("Upstream credit returned at %0t with no request outstanding", $time);
        end
      end
      if (resp_valid) begin
        if (resp_seen >= exp_q.size()) begin
          err_stream++;
          $display("Response with tag %0h arrived with no request outstanding", resp.tag);
        end else begin
          check_resp(resp, exp_q[resp_seen]);
        end
        resp_seen++;
      end
    end
  end

  initial begin
    pma_reg_u    word;
    logic [11:0] addr;
    logic [3:0]  next_tag;
    int          base;
    void'($urandom(32'hb64a8fe5));
    nRST      = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    csr_addr  = '0;
    csr_wen   = 1'b0;
    csr_wdata = '0;
    next_tag  = '0;
    // Reset map has RAM below region 8 and IO from there up
    for (int i = 0; i < N_REGIONS; i++) begin
      word.half.cfg_0 = (i < 8) ? RAM_CFG : IO_CFG;
      word.half.cfg_1 = word.half.cfg_0;
      model_regs[i]   = word;
    end
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;

    // Reset values through both windows
    for (int i = 0; i < N_REGIONS; i++) begin
      csr_read({8'hBC, 4'(i)}, 1'b1, model_regs[i]);
      csr_read({8'hCC, 4'(i)}, 1'b1, model_regs[i]);
    end
    // Outside both windows
    repeat (8) begin
      addr = 12'($urandom);
      if (addr[11:4] == 8'hBC || addr[11:4] == 8'hCC) addr[11:8] = 4'h0;
      csr_read(addr, 1'b0, '0);
    end

    // Random writes into either window with read-back through both
    repeat (48) begin
      addr     = {($urandom_range(1) == 0) ? 8'hBC : 8'hCC, 4'($urandom_range(15))};
      word.raw = $urandom;
      csr_write(addr, word);
      csr_read({8'hBC, addr[3:0]}, 1'b1, model_regs[addr[3:0]]);
      csr_read({8'hCC, addr[3:0]}, 1'b1, model_regs[addr[3:0]]);
    end

    // CSR phase followed by a request burst on the idle pipeline
    repeat (8) begin
      repeat (4) begin
        word.raw = $urandom;
        csr_write({8'hBC, 4'($urandom_range(15))}, word);
      end
      repeat (12) begin
        send_req(random_req(next_tag));
        next_tag++;
      end
      drain("fault check round");
    end

    // Downstream back-pressure with random request gaps
    slow_credits = 1'b1;
    repeat (80) begin
      if ($urandom_range(3) == 0) begin
        @(posedge CLK);
        req_valid <= 1'b0;
      end
      send_req(random_req(next_tag));
      next_tag++;
    end
    drain("back-pressure stream");
    slow_credits = 1'b0;

    // Full rate with prompt credit return
    base = up_returned;
    repeat (100) begin
      send_req(random_req(next_tag));
      next_tag++;
    end
    drain("full-rate stream");
    if (!timed_out && up_returned - base != 100) begin
      err_misc++;
      $display("Upstream credits returned %0d times for 100 requests", up_returned - base);
    end
    end_run();
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/pma_pkg.sv
rtl/pma_attr_regs.sv
rtl/pma_req_queue.sv
rtl/pma_lookup_stage.sv
rtl/pma_check_stage.sv
rtl/pma_checker_top.sv
sim/pma_checker_properties.sv
sim/pma_checker_tb.sv

//--- Makefile
# Verilator build and run for the PMA checker testbench

VERILATOR ?= verilator
TOP       ?= pma_checker_tb
SEED      ?= 1
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

# Sources taken from the file list so the binary tracks every change
SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST) Makefile
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Pass only when the testbench printed its pass line
run: $(BIN)
	@out="$$(./$(BIN) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
